/* des_config.svh */
`ifndef DES_CONFIG_SVH
`define DES_CONFIG_SVH

// --------------------------------------------------
// DES core sizing
// --------------------------------------------------

// Block and raw key width
`define DES_BLOCK_W     64

// One Feistel half
`define DES_HALF_W      32

// One C or D key register
`define DES_KHALF_W     28

// Round key after PC2
`define DES_SUBKEY_W    48

// Rounds per block
`define DES_ROUNDS      16

// Output credits held by the core after reset
`define DES_OUT_CREDITS 2

`endif

/* des_pkg.sv */
`default_nettype none

`include "des_config.svh"

package des_pkg;

    typedef logic [`DES_BLOCK_W-1:0]  des_block_t;
    typedef logic [`DES_HALF_W-1:0]   des_half_t;
    typedef logic [`DES_KHALF_W-1:0]  des_khalf_t;
    typedef logic [`DES_SUBKEY_W-1:0] des_subkey_t;
    typedef logic [$clog2(`DES_ROUNDS)-1:0]        des_round_t;
    typedef logic [$clog2(`DES_OUT_CREDITS+1)-1:0] des_credit_t;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_ROUND = 2'd1,
        S_HOLD  = 2'd2
    } des_state_t;

    // --------------------------------------------------
    // Permutation tables, bit 1 is the MSB
    // --------------------------------------------------

    localparam int DES_IP_TBL [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2,  60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,  64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9,  1,  59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,  63, 55, 47, 39, 31, 23, 15, 7
    };

    // Inverse of IP
    localparam int DES_FP_TBL [64] = '{
        40, 8, 48, 16, 56, 24, 64, 32,  39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,  37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,  35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,  33, 1, 41, 9,  49, 17, 57, 25
    };

    // Expansion of R from 32 to 48 bits
    localparam int DES_E_TBL [48] = '{
        32, 1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
        8,  9,  10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam int DES_P_TBL [32] = '{
        16, 7,  20, 21, 29, 12, 28, 17, 1,  15, 23, 26, 5,  18, 31, 10,
        2,  8,  24, 14, 32, 27, 3,  9,  19, 13, 30, 6,  22, 11, 4,  25
    };

    localparam int DES_PC1_C_TBL [28] = '{
        57, 49, 41, 33, 25, 17, 9,  1,  58, 50, 42, 34, 26, 18,
        10, 2,  59, 51, 43, 35, 27, 19, 11, 3,  60, 52, 44, 36
    };

    localparam int DES_PC1_D_TBL [28] = '{
        63, 55, 47, 39, 31, 23, 15, 7,  62, 54, 46, 38, 30, 22,
        14, 6,  61, 53, 45, 37, 29, 21, 13, 5,  28, 20, 12, 4
    };

    // Selects 48 of the 56 C/D bits
    localparam int DES_PC2_TBL [48] = '{
        14, 17, 11, 24, 1,  5,  3,  28, 15, 6,  21, 10,
        23, 19, 12, 4,  26, 8,  16, 7,  27, 20, 13, 2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // --------------------------------------------------
    // S-boxes, row-major with 16 columns per row
    // --------------------------------------------------

    localparam int DES_SBOX [8][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

    // --------------------------------------------------
    // Permutation and round functions
    // --------------------------------------------------

    function automatic des_block_t des_ip(des_block_t b);
        des_block_t r;
        for (int i = 0; i < 64; i++) begin
            r[63 - i] = b[64 - DES_IP_TBL[i]];
        end
        return r;
    endfunction

    function automatic des_block_t des_fp(des_block_t b);
        des_block_t r;
        for (int i = 0; i < 64; i++) begin
            r[63 - i] = b[64 - DES_FP_TBL[i]];
        end
        return r;
    endfunction

    // Parity bits of the key are dropped here
    function automatic des_khalf_t des_pc1_c(des_block_t k);
        des_khalf_t c;
        for (int i = 0; i < 28; i++) begin
            c[27 - i] = k[64 - DES_PC1_C_TBL[i]];
        end
        return c;
    endfunction

    function automatic des_khalf_t des_pc1_d(des_block_t k);
        des_khalf_t d;
        for (int i = 0; i < 28; i++) begin
            d[27 - i] = k[64 - DES_PC1_D_TBL[i]];
        end
        return d;
    endfunction

    function automatic des_subkey_t des_pc2(des_khalf_t c, des_khalf_t d);
        logic [2*`DES_KHALF_W-1:0] cd;
        des_subkey_t k;
        cd = {c, d};
        for (int i = 0; i < 48; i++) begin
            k[47 - i] = cd[56 - DES_PC2_TBL[i]];
        end
        return k;
    endfunction

    // E, key mix, S-box lookup and P in one step
    function automatic des_half_t des_f(des_half_t r, des_subkey_t k);
        des_subkey_t e;
        des_subkey_t x;
        logic [5:0]  six;
        des_half_t   s_out;
        des_half_t   f;
        for (int i = 0; i < 48; i++) begin
            e[47 - i] = r[32 - DES_E_TBL[i]];
        end
        x = e ^ k;
        // Outer bits pick the row, inner four the column
        for (int s = 0; s < 8; s++) begin
            six = x[47 - 6*s -: 6];
            s_out[31 - 4*s -: 4] = 4'(DES_SBOX[s][{six[5], six[0], six[4:1]}]);
        end
        for (int i = 0; i < 32; i++) begin
            f[31 - i] = s_out[32 - DES_P_TBL[i]];
        end
        return f;
    endfunction

endpackage

`default_nettype wire

/* des_round_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_round_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic round_en,
    input  logic decrypt,
    output logic last_round,
    output logic single_shift
);

    import des_pkg::*;

    des_round_t round_idx;

    // Index 0 during the first round cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round_idx <= '0;
        end else if (load) begin
            round_idx <= '0;
        end else if (round_en) begin
            round_idx <= round_idx + 1'b1;
        end
    end

    assign last_round = round_en && (round_idx == des_round_t'(`DES_ROUNDS - 1));

    // Encrypt shifts by one in rounds 1, 2, 9 and 16
    // Decrypt undoes them in reverse order, after rounds 1, 8 and 15
    always_comb begin
        if (decrypt) begin
            single_shift = (round_idx == 4'd0) || (round_idx == 4'd7) || (round_idx == 4'd14);
        end else begin
            single_shift = (round_idx == 4'd0) || (round_idx == 4'd1) ||
                           (round_idx == 4'd8) || (round_idx == 4'd15);
        end
    end

endmodule

`default_nettype wire

/* des_control_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_control_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic in_decrypt,
    input  logic out_credit,
    input  logic last_round,
    output logic load,
    output logic round_en,
    output logic decrypt,
    output logic in_credit,
    output logic out_valid
);

    import des_pkg::*;

    des_state_t  state_q;
    des_state_t  state_d;
    logic        decrypt_q;
    des_credit_t credit_q;
    logic        armed_q;
    logic        boot_q;

    // --------------------------------------------------
    // Sequencing
    // --------------------------------------------------

    assign load      = (state_q == S_IDLE) && in_valid;
    assign round_en  = (state_q == S_ROUND);
    assign out_valid = (state_q == S_HOLD) && (credit_q != '0);
    assign decrypt   = decrypt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:  if (in_valid) state_d = S_ROUND;
            S_ROUND: if (last_round) state_d = S_HOLD;
            S_HOLD:  if (out_valid) state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            decrypt_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load) begin
                decrypt_q <= in_decrypt;
            end
        end
    end

    // --------------------------------------------------
    // Output credits
    // --------------------------------------------------

    // Simultaneous return and spend leaves the count unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= des_credit_t'(`DES_OUT_CREDITS);
        end else begin
            case ({out_credit, out_valid})
                2'b10: begin
                    if (credit_q != des_credit_t'(`DES_OUT_CREDITS)) begin
                        credit_q <= credit_q + 1'b1;
                    end
                end
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    // --------------------------------------------------
    // Input credits
    // --------------------------------------------------

    // One pulse after reset, then one per result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed_q <= 1'b0;
            boot_q  <= 1'b0;
        end else begin
            armed_q <= 1'b1;
            boot_q  <= !armed_q;
        end
    end

    assign in_credit = boot_q || out_valid;

endmodule

`default_nettype wire

/* des_key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_key_schedule (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic                 round_en,
    input  logic                 decrypt,
    input  logic                 single_shift,
    input  des_pkg::des_block_t  key,
    output des_pkg::des_subkey_t round_key
);

    import des_pkg::*;

    localparam int W = `DES_KHALF_W;

    des_khalf_t c_q;
    des_khalf_t d_q;
    des_khalf_t c_rotl;
    des_khalf_t d_rotl;
    des_khalf_t c_rotr;
    des_khalf_t d_rotr;

    function automatic des_khalf_t rot_left(des_khalf_t v, logic one);
        return one ? {v[W-2:0], v[W-1]} : {v[W-3:0], v[W-1 -: 2]};
    endfunction

    function automatic des_khalf_t rot_right(des_khalf_t v, logic one);
        return one ? {v[0], v[W-1:1]} : {v[1:0], v[W-1:2]};
    endfunction

    assign c_rotl = rot_left(c_q, single_shift);
    assign d_rotl = rot_left(d_q, single_shift);
    assign c_rotr = rot_right(c_q, single_shift);
    assign d_rotr = rot_right(d_q, single_shift);

    // Decrypt starts from C0/D0, which equals C16/D16
    assign round_key = decrypt ? des_pc2(c_q, d_q) : des_pc2(c_rotl, d_rotl);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_q <= '0;
            d_q <= '0;
        end else if (load) begin
            c_q <= des_pc1_c(key);
            d_q <= des_pc1_d(key);
        end else if (round_en) begin
            c_q <= decrypt ? c_rotr : c_rotl;
            d_q <= decrypt ? d_rotr : d_rotl;
        end
    end

endmodule

`default_nettype wire

/* des_feistel_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_feistel_datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic                 round_en,
    input  des_pkg::des_block_t  block,
    input  des_pkg::des_subkey_t round_key,
    output des_pkg::des_block_t  result
);

    import des_pkg::*;

    des_half_t  l_q;
    des_half_t  r_q;
    des_block_t block_ip;
    des_half_t  f_out;

    assign block_ip = des_ip(block);
    assign f_out    = des_f(r_q, round_key);

    // --------------------------------------------------
    // One round per enabled cycle
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            l_q <= '0;
            r_q <= '0;
        end else if (load) begin
            l_q <= block_ip[`DES_BLOCK_W-1 -: `DES_HALF_W];
            r_q <= block_ip[`DES_HALF_W-1:0];
        end else if (round_en) begin
            l_q <= r_q;
            r_q <= l_q ^ f_out;
        end
    end

    // Halves swap back before FP, so R16 comes first
    assign result = des_fp({r_q, l_q});

endmodule

`default_nettype wire

/* des_top.sv */
`timescale 1ns/1ps
`default_nettype none

module des_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                in_decrypt,
    input  des_pkg::des_block_t in_block,
    input  des_pkg::des_block_t in_key,
    input  logic                out_credit,
    output logic                in_credit,
    output logic                out_valid,
    output des_pkg::des_block_t out_block
);

    import des_pkg::*;

    logic        load;
    logic        round_en;
    logic        decrypt;
    logic        last_round;
    logic        single_shift;
    des_subkey_t round_key;

    des_control_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_decrypt (in_decrypt),
        .out_credit (out_credit),
        .last_round (last_round),
        .load       (load),
        .round_en   (round_en),
        .decrypt    (decrypt),
        .in_credit  (in_credit),
        .out_valid  (out_valid)
    );

    des_round_counter u_counter (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .round_en     (round_en),
        .decrypt      (decrypt),
        .last_round   (last_round),
        .single_shift (single_shift)
    );

    des_key_schedule u_key_schedule (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .round_en     (round_en),
        .decrypt      (decrypt),
        .single_shift (single_shift),
        .key          (in_key),
        .round_key    (round_key)
    );

    // Result stays on out_block until the next load
    des_feistel_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .round_en  (round_en),
        .block     (in_block),
        .round_key (round_key),
        .result    (out_block)
    );

endmodule

`default_nettype wire

/* tb_des_ref.svh */
`ifndef TB_DES_REF_SVH
`define TB_DES_REF_SVH

// --------------------------------------------------
// DES reference model, bit 1 is the MSB of each word
// --------------------------------------------------

localparam int ref_ip [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2,  60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6,  64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9,  1,  59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5,  63, 55, 47, 39, 31, 23, 15, 7
};

localparam int ref_e [48] = '{
    32, 1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9,  10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
};

localparam int ref_p [32] = '{
    16, 7,  20, 21, 29, 12, 28, 17, 1,  15, 23, 26, 5,  18, 31, 10,
    2,  8,  24, 14, 32, 27, 3,  9,  19, 13, 30, 6,  22, 11, 4,  25
};

// C half in the first 28 entries, D half after
localparam int ref_pc1 [56] = '{
    57, 49, 41, 33, 25, 17, 9,  1,  58, 50, 42, 34, 26, 18,
    10, 2,  59, 51, 43, 35, 27, 19, 11, 3,  60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7,  62, 54, 46, 38, 30, 22,
    14, 6,  61, 53, 45, 37, 29, 21, 13, 5,  28, 20, 12, 4
};

localparam int ref_pc2 [48] = '{
    14, 17, 11, 24, 1,  5,  3,  28, 15, 6,  21, 10, 23, 19, 12, 4,
    26, 8,  16, 7,  27, 20, 13, 2,  41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
};

localparam int ref_shifts [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

// One word per S-box row, column 0 in the top nibble
localparam logic [63:0] ref_sbox_rows [32] = '{
    64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538, 64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D,
    64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5, 64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9,
    64'hA09E63F51DC7B428, 64'hD709346A285ECBF1, 64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C,
    64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9, 64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E,
    64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986, 64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453,
    64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38, 64'h9EF528C3704A1DB6, 64'h432C95FABE17608D,
    64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86, 64'h14BDC37EAF680592, 64'h6BD814A7950FE23C,
    64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92, 64'h7B419CE206ADF358, 64'h21E74A8DFC90356B
};

function automatic logic [63:0] des_ref(logic [63:0] block, logic [63:0] key, logic decrypt);
    logic [55:0] cd;
    logic [27:0] c;
    logic [27:0] d;
    logic [47:0] subkeys [16];
    logic [63:0] v;
    logic [31:0] l;
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] f;
    logic [47:0] x;
    logic [5:0]  six;
    logic [63:0] pre;
    logic [63:0] res;
    int          k;

    // All sixteen subkeys up front
    for (int i = 0; i < 56; i++) begin
        cd[55 - i] = key[64 - ref_pc1[i]];
    end
    c = cd[55:28];
    d = cd[27:0];
    for (int n = 0; n < 16; n++) begin
        for (int j = 0; j < ref_shifts[n]; j++) begin
            c = {c[26:0], c[27]};
            d = {d[26:0], d[27]};
        end
        cd = {c, d};
        for (int i = 0; i < 48; i++) begin
            subkeys[n][47 - i] = cd[56 - ref_pc2[i]];
        end
    end

    for (int i = 0; i < 64; i++) begin
        v[63 - i] = block[64 - ref_ip[i]];
    end
    l = v[63:32];
    r = v[31:0];

    // Decryption walks the subkeys backwards
    for (int n = 0; n < 16; n++) begin
        k = decrypt ? 15 - n : n;
        for (int i = 0; i < 48; i++) begin
            x[47 - i] = r[32 - ref_e[i]];
        end
        x = x ^ subkeys[k];
        for (int b = 0; b < 8; b++) begin
            six = x[47 - 6*b -: 6];
            s[31 - 4*b -: 4] = ref_sbox_rows[4*b + 2*six[5] + six[0]][63 - 4*six[4:1] -: 4];
        end
        for (int i = 0; i < 32; i++) begin
            f[31 - i] = s[32 - ref_p[i]];
        end
        f = f ^ l;
        l = r;
        r = f;
    end

    // FP undoes IP, so scatter back through the IP table
    pre = {r, l};
    for (int i = 0; i < 64; i++) begin
        res[64 - ref_ip[i]] = pre[63 - i];
    end
    return res;
endfunction

`endif

/* tb_des_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module tb_des_top;

    import des_pkg::*;

    `include "tb_des_ref.svh"

    localparam int LATENCY      = 17;
    localparam int RAND_COUNT   = 100;
    localparam int BP_BLOCKS    = `DES_OUT_CREDITS + 1;
    localparam int TOTAL_BLOCKS = 2 + 3 * RAND_COUNT + BP_BLOCKS;
    localparam int CYCLE_LIMIT  = 40 * TOTAL_BLOCKS + 400;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_decrypt;
    des_block_t in_block;
    des_block_t in_key;
    logic       out_credit;
    logic       in_credit;
    logic       out_valid;
    des_block_t out_block;

    des_block_t exp_q [$];
    int         sent_q [$];
    des_block_t plain_mem [RAND_COUNT];
    des_block_t key_mem [RAND_COUNT];
    des_block_t cipher_mem [RAND_COUNT];

    integer seed;
    int     cyc;
    int     sent_cycle;
    int     credits_got;
    int     credits_used;
    int     boot_pulses;
    int     results_seen;
    int     returned;
    int     checks;
    int     errors;
    int     tests_run;
    int     tests_failed;
    bit     auto_return;
    bit     check_latency;

    always #2 clk = ~clk;

    des_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_decrypt (in_decrypt),
        .in_block   (in_block),
        .in_key     (in_key),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_block  (out_block)
    );

    // --------------------------------------------------
    // Checking helpers
    // --------------------------------------------------

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0d ns: %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    // --------------------------------------------------
    // Host and consumer
    // --------------------------------------------------

    // Waits for an input credit, then holds in_valid for one cycle
    task automatic send_block(input des_block_t blk, input des_block_t key,
                              input logic dec, input des_block_t exp);
        @(posedge clk);
        while (credits_got == credits_used) begin
            @(posedge clk);
        end
        in_valid   <= 1'b1;
        in_decrypt <= dec;
        in_block   <= blk;
        in_key     <= key;
        credits_used++;
        exp_q.push_back(exp);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // One out_credit pulse per result seen while returns are enabled
    always @(posedge clk) begin
        if (auto_return && returned < results_seen) begin
            out_credit <= 1'b1;
            returned++;
        end else begin
            out_credit <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Monitor and comparison at mid-cycle
    // --------------------------------------------------

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (!rst_n) begin
            check_value("out_valid during reset", 64'(out_valid), 64'd0);
            check_value("in_credit during reset", 64'(in_credit), 64'd0);
        end else begin
            if (in_valid) begin
                sent_q.push_back(cyc);
            end
            if (in_credit) begin
                credits_got++;
                check_value("input credits held by host", 64'(credits_got - credits_used), 64'd1);
                if (!out_valid) begin
                    boot_pulses++;
                end
            end
            if (out_valid) begin
                results_seen++;
                check_value("in_credit with out_valid", 64'(in_credit), 64'd1);
                if (exp_q.size() == 0 || sent_q.size() == 0) begin
                    report_failure("out_valid seen with no block in flight");
                end else begin
                    check_value("out_block", out_block, exp_q.pop_front());
                    sent_cycle = sent_q.pop_front();
                    if (check_latency) begin
                        check_value("cycles from in_valid to out_valid",
                                    64'(cyc - sent_cycle), 64'(LATENCY));
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (cyc > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles, %0d results outstanding",
                     CYCLE_LIMIT, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        int         e0;
        int         seen0;
        des_block_t pt;
        des_block_t ky;

        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_decrypt    = 1'b0;
        in_block      = '0;
        in_key        = '0;
        out_credit    = 1'b0;
        seed          = 32'h53ba75f9;
        auto_return   = 1'b1;
        check_latency = 1'b1;

        // Reset checks count toward the first test
        e0 = errors;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Boot credit arrives on its own
        repeat (8) @(posedge clk);
        check_value("in_credit pulses after reset", 64'(boot_pulses), 64'd1);
        check_value("credits before any input", 64'(credits_got - credits_used), 64'd1);
        finish_test("reset and boot credit", e0);

        e0 = errors;
        check_value("reference known vector",
                    des_ref(64'h0123456789ABCDEF, 64'h133457799BBCDFF1, 1'b0),
                    64'h85E813540F0AB405);
        send_block(64'h0123456789ABCDEF, 64'h133457799BBCDFF1, 1'b0, 64'h85E813540F0AB405);
        send_block(64'h85E813540F0AB405, 64'h133457799BBCDFF1, 1'b1, 64'h0123456789ABCDEF);
        wait_drain();
        finish_test("known vector", e0);

        e0 = errors;
        for (int i = 0; i < RAND_COUNT; i++) begin
            plain_mem[i]  = {$random(seed), $random(seed)};
            key_mem[i]    = {$random(seed), $random(seed)};
            cipher_mem[i] = des_ref(plain_mem[i], key_mem[i], 1'b0);
            send_block(plain_mem[i], key_mem[i], 1'b0, cipher_mem[i]);
        end
        wait_drain();
        finish_test("random encryption", e0);

        e0 = errors;
        for (int i = 0; i < RAND_COUNT; i++) begin
            pt = {$random(seed), $random(seed)};
            ky = {$random(seed), $random(seed)};
            send_block(pt, ky, 1'b1, des_ref(pt, ky, 1'b1));
        end
        // Round trip on the ciphertexts of the encryption run
        for (int i = 0; i < RAND_COUNT; i++) begin
            send_block(cipher_mem[i], key_mem[i], 1'b1, plain_mem[i]);
        end
        wait_drain();
        finish_test("random decryption and round trip", e0);

        e0 = errors;
        check_latency = 1'b0;
        auto_return   = 1'b0;
        seen0         = results_seen;
        for (int i = 0; i < BP_BLOCKS; i++) begin
            pt = {$random(seed), $random(seed)};
            ky = {$random(seed), $random(seed)};
            send_block(pt, ky, i[0], des_ref(pt, ky, i[0]));
        end
        repeat (100) begin
            @(negedge clk);
            check_value("out_valid without output credit", 64'(out_valid), 64'd0);
            check_value("in_credit without output credit", 64'(in_credit), 64'd0);
        end
        check_value("results before stall", 64'(results_seen - seen0), 64'(`DES_OUT_CREDITS));
        auto_return = 1'b1;
        wait_drain();
        check_latency = 1'b1;
        finish_test("output back-pressure", e0);

        e0 = errors;
        check_value("in_credit pulses without out_valid", 64'(boot_pulses), 64'd1);
        check_value("results for blocks sent", 64'(results_seen), 64'(credits_used));
        check_value("credits left with host", 64'(credits_got - credits_used), 64'd1);
        finish_test("credit pairing", e0);

        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
des_pkg.sv
des_round_counter.sv
des_control_fsm.sv
des_key_schedule.sv
des_feistel_datapath.sv
des_top.sv
tb_des_top.sv

/* Makefile */
# Verilator build and run of the DES testbench

VERILATOR ?= verilator
TOP       ?= tb_des_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
